/* Makefile */
TOP = tb_decode_stage
LOG = sim.log

all: run

build:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean

/* logic/branch_unit.sv */
// branch compare and redirect target select for branches, jumps, ecall and mret
`timescale 1ns/10ps

module branch_unit (
  input  logic                           i_valid,
  input  rv_decode_pkg::dec_ctrl_t       i_ctrl,
  input  logic [rv_decode_pkg::XLEN-1:0] i_pc,
  input  logic [rv_decode_pkg::XLEN-1:0] i_imm,
  input  logic [rv_decode_pkg::XLEN-1:0] i_rs1_data,
  input  logic [rv_decode_pkg::XLEN-1:0] i_rs2_data,
  input  logic [rv_decode_pkg::XLEN-1:0] i_mtvec,
  input  logic [rv_decode_pkg::XLEN-1:0] i_mepc,
  output rv_decode_pkg::br_t             o_br
);

  logic                           cond;
  logic [rv_decode_pkg::XLEN-1:0] jalr_sum;

  assign jalr_sum = i_rs1_data + i_imm;

  always_comb begin
    case (i_ctrl.br_func)
      rv_decode_pkg::F3_BEQ:  cond = (i_rs1_data == i_rs2_data);
      rv_decode_pkg::F3_BNE:  cond = (i_rs1_data != i_rs2_data);
      rv_decode_pkg::F3_BLT:  cond = ($signed(i_rs1_data) < $signed(i_rs2_data));
      rv_decode_pkg::F3_BGE:  cond = ($signed(i_rs1_data) >= $signed(i_rs2_data));
      rv_decode_pkg::F3_BLTU: cond = (i_rs1_data < i_rs2_data);
      rv_decode_pkg::F3_BGEU: cond = (i_rs1_data >= i_rs2_data);
      default:                cond = 1'b0;
    endcase
  end

  always_comb begin
    o_br.taken = i_valid &&
                 ((i_ctrl.br_en && cond) || i_ctrl.jump || i_ctrl.ecall || i_ctrl.mret);
    if (i_ctrl.ecall) begin
      o_br.target = i_mtvec;
    end else if (i_ctrl.mret) begin
      o_br.target = i_mepc;
    end else if (i_ctrl.jalr) begin
      o_br.target = {jalr_sum[rv_decode_pkg::XLEN-1:1], 1'b0}; // lsb cleared
    end else begin
      o_br.target = i_pc + i_imm; // branch and jal
    end
  end

endmodule

/* logic/csr_file.sv */
// machine-mode csr file with read port, write-back port and ecall trap update
`timescale 1ns/10ps

module csr_file (
  input  logic                             i_clk,
  input  logic                             i_rst_n,
  input  logic                             i_ren,
  input  logic [rv_decode_pkg::CSR_AW-1:0] i_raddr,
  output logic [rv_decode_pkg::XLEN-1:0]   o_rdata,
  input  logic                             i_wen,
  input  logic [rv_decode_pkg::CSR_AW-1:0] i_waddr,
  input  logic [rv_decode_pkg::XLEN-1:0]   i_wdata,
  input  logic                             i_ecall, // one pulse per ecall leaving decode
  input  logic [rv_decode_pkg::XLEN-1:0]   i_epc,
  output logic [rv_decode_pkg::XLEN-1:0]   o_mtvec,
  output logic [rv_decode_pkg::XLEN-1:0]   o_mepc
);

  logic [rv_decode_pkg::XLEN-1:0] mstatus;
  logic [rv_decode_pkg::XLEN-1:0] mtvec;
  logic [rv_decode_pkg::XLEN-1:0] mepc;
  logic [rv_decode_pkg::XLEN-1:0] mcause;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      mstatus <= '0;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (i_wen) begin
        case (i_waddr)
          rv_decode_pkg::CSR_MSTATUS: mstatus <= i_wdata;
          rv_decode_pkg::CSR_MTVEC:   mtvec   <= i_wdata;
          rv_decode_pkg::CSR_MEPC:    mepc    <= i_wdata;
          rv_decode_pkg::CSR_MCAUSE:  mcause  <= i_wdata;
          default: ;
        endcase
      end
      // trap entry overrides a same-cycle write-back
      if (i_ecall) begin
        mepc   <= i_epc;
        mcause <= rv_decode_pkg::CAUSE_ECALL_M;
      end
    end
  end

  always_comb begin
    o_rdata = '0;
    if (i_ren) begin
      case (i_raddr)
        rv_decode_pkg::CSR_MSTATUS: o_rdata = mstatus;
        rv_decode_pkg::CSR_MTVEC:   o_rdata = mtvec;
        rv_decode_pkg::CSR_MEPC:    o_rdata = mepc;
        rv_decode_pkg::CSR_MCAUSE:  o_rdata = mcause;
        default:                    o_rdata = '0;
      endcase
    end
  end

  assign o_mtvec = mtvec;
  assign o_mepc  = mepc;

endmodule

/* logic/decode_stage.sv */
// decode stage top: valid/allowin handshake, input register, decoder and register files
`timescale 1ns/10ps

module decode_stage (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  input  logic                     i_fs_to_ds_valid,
  input  rv_decode_pkg::fs_to_ds_t i_fs_to_ds,
  output logic                     o_ds_allowin,
  output logic                     o_ds_to_es_valid,
  output rv_decode_pkg::ds_to_es_t o_ds_to_es,
  input  logic                     i_es_allowin,
  output rv_decode_pkg::br_t       o_br,
  input  rv_decode_pkg::ws_to_rf_t i_ws_to_rf
);

  logic                             ds_valid;
  logic                             ds_leave;
  rv_decode_pkg::fs_to_ds_t         ds_r;
  logic [rv_decode_pkg::REG_AW-1:0] rs1;
  logic [rv_decode_pkg::REG_AW-1:0] rs2;
  logic [rv_decode_pkg::REG_AW-1:0] rd;
  logic [rv_decode_pkg::XLEN-1:0]   imm;
  logic [rv_decode_pkg::CSR_AW-1:0] csr_addr;
  rv_decode_pkg::dec_ctrl_t         ctrl;
  logic [rv_decode_pkg::XLEN-1:0]   rs1_data;
  logic [rv_decode_pkg::XLEN-1:0]   rs2_data;
  logic [rv_decode_pkg::XLEN-1:0]   csr_rdata;
  logic [rv_decode_pkg::XLEN-1:0]   mtvec;
  logic [rv_decode_pkg::XLEN-1:0]   mepc;

  // decode never stalls on its own
  assign o_ds_allowin     = !ds_valid || i_es_allowin;
  assign o_ds_to_es_valid = ds_valid;
  assign ds_leave         = ds_valid && i_es_allowin;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      ds_valid <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin
      ds_r <= i_fs_to_ds;
    end
  end

  inst_decoder u_dec (
    .i_inst     (ds_r.inst),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .o_rd       (rd),
    .o_imm      (imm),
    .o_csr_addr (csr_addr),
    .o_ctrl     (ctrl)
  );

  gpr_file u_gpr (
    .i_clk    (i_clk),
    .i_raddr1 (rs1),
    .o_rdata1 (rs1_data),
    .i_raddr2 (rs2),
    .o_rdata2 (rs2_data),
    .i_wen    (i_ws_to_rf.gpr_wen),
    .i_waddr  (i_ws_to_rf.gpr_waddr),
    .i_wdata  (i_ws_to_rf.gpr_wdata)
  );

  csr_file u_csr (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_ren   (ctrl.csr_ren),
    .i_raddr (csr_addr),
    .o_rdata (csr_rdata),
    .i_wen   (i_ws_to_rf.csr_wen),
    .i_waddr (i_ws_to_rf.csr_waddr),
    .i_wdata (i_ws_to_rf.csr_wdata),
    .i_ecall (ctrl.ecall && ds_leave), // once per ecall, even when stalled
    .i_epc   (ds_r.pc),
    .o_mtvec (mtvec),
    .o_mepc  (mepc)
  );

  branch_unit u_bru (
    .i_valid    (ds_valid),
    .i_ctrl     (ctrl),
    .i_pc       (ds_r.pc),
    .i_imm      (imm),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .i_mtvec    (mtvec),
    .i_mepc     (mepc),
    .o_br       (o_br)
  );

  always_comb begin
    o_ds_to_es.rs1_data     = rs1_data;
    o_ds_to_es.rs2_data     = rs2_data;
    o_ds_to_es.csr_rdata    = csr_rdata;
    o_ds_to_es.imm          = imm;
    o_ds_to_es.pc           = ds_r.pc;
    o_ds_to_es.alu_src1_pc  = ctrl.alu_src1_pc;
    o_ds_to_es.alu_src2_sel = ctrl.alu_src2_sel;
    o_ds_to_es.alu_word     = ctrl.alu_word;
    o_ds_to_es.alu_op       = ctrl.alu_op;
    o_ds_to_es.rd           = rd;
    o_ds_to_es.csr_addr     = csr_addr;
    o_ds_to_es.gpr_wen      = ctrl.gpr_wen;
    o_ds_to_es.csr_wen      = ctrl.csr_wen;
    o_ds_to_es.mem_ren      = ctrl.mem_ren;
    o_ds_to_es.mem_wen      = ctrl.mem_wen;
    o_ds_to_es.mem_op       = ctrl.mem_op;
    o_ds_to_es.csr_to_gpr   = ctrl.csr_to_gpr;
    o_ds_to_es.csr_op       = ctrl.csr_op;
    o_ds_to_es.ebreak       = ctrl.ebreak;
    o_ds_to_es.invalid      = ctrl.invalid;
  end

endmodule

/* logic/gpr_file.sv */
// general register file, 32 x 64 bit, two read ports and one write port
`timescale 1ns/10ps

module gpr_file (
  input  logic                             i_clk,
  input  logic [rv_decode_pkg::REG_AW-1:0] i_raddr1,
  output logic [rv_decode_pkg::XLEN-1:0]   o_rdata1,
  input  logic [rv_decode_pkg::REG_AW-1:0] i_raddr2,
  output logic [rv_decode_pkg::XLEN-1:0]   o_rdata2,
  input  logic                             i_wen,
  input  logic [rv_decode_pkg::REG_AW-1:0] i_waddr,
  input  logic [rv_decode_pkg::XLEN-1:0]   i_wdata
);

  logic [rv_decode_pkg::XLEN-1:0] regs [31:1]; // x0 has no storage

  always_ff @(posedge i_clk) begin
    if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

/* logic/inst_decoder.sv */
// instruction decoder: register indices, immediate generation and control fields
`timescale 1ns/10ps

module inst_decoder (
  input  rv_decode_pkg::inst_u                 i_inst,
  output logic [rv_decode_pkg::REG_AW-1:0]     o_rs1,
  output logic [rv_decode_pkg::REG_AW-1:0]     o_rs2,
  output logic [rv_decode_pkg::REG_AW-1:0]     o_rd,
  output logic [rv_decode_pkg::XLEN-1:0]       o_imm,
  output logic [rv_decode_pkg::CSR_AW-1:0]     o_csr_addr,
  output rv_decode_pkg::dec_ctrl_t             o_ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       bad;

  function automatic rv_decode_pkg::alu_op_e alu_from_f3(input logic [2:0] f3,
                                                         input logic       alt);
    case (f3)
      3'b000:  alu_from_f3 = alt ? rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
      3'b001:  alu_from_f3 = rv_decode_pkg::ALU_SLL;
      3'b010:  alu_from_f3 = rv_decode_pkg::ALU_SLT;
      3'b011:  alu_from_f3 = rv_decode_pkg::ALU_SLTU;
      3'b100:  alu_from_f3 = rv_decode_pkg::ALU_XOR;
      3'b101:  alu_from_f3 = alt ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
      3'b110:  alu_from_f3 = rv_decode_pkg::ALU_OR;
      default: alu_from_f3 = rv_decode_pkg::ALU_AND;
    endcase
  endfunction

  assign opcode     = i_inst.r.opcode;
  assign funct3     = i_inst.r.funct3;
  assign funct7     = i_inst.r.funct7;
  assign o_rs1      = i_inst.r.rs1;
  assign o_rs2      = i_inst.r.rs2;
  assign o_rd       = i_inst.r.rd;   // same slot in every format that has rd
  assign o_csr_addr = i_inst.i.imm;

  always_comb begin
    case (opcode)
      rv_decode_pkg::OP_STORE:
        o_imm = {{52{i_inst.s.imm_hi[6]}}, i_inst.s.imm_hi, i_inst.s.imm_lo};
      rv_decode_pkg::OP_BRANCH:
        o_imm = {{51{i_inst.b.imm12}}, i_inst.b.imm12, i_inst.b.imm11,
                 i_inst.b.imm10_5, i_inst.b.imm4_1, 1'b0};
      rv_decode_pkg::OP_LUI, rv_decode_pkg::OP_AUIPC:
        o_imm = {{32{i_inst.u.imm[19]}}, i_inst.u.imm, 12'b0};
      rv_decode_pkg::OP_JAL:
        o_imm = {{43{i_inst.j.imm20}}, i_inst.j.imm20, i_inst.j.imm19_12,
                 i_inst.j.imm11, i_inst.j.imm10_1, 1'b0};
      rv_decode_pkg::OP_SYSTEM: // zimm of the csr*i forms
        o_imm = {{(rv_decode_pkg::XLEN-rv_decode_pkg::REG_AW){1'b0}}, i_inst.r.rs1};
      default:
        o_imm = {{52{i_inst.i.imm[11]}}, i_inst.i.imm};
    endcase
  end

  always_comb begin
    o_ctrl              = '0;
    o_ctrl.alu_op       = rv_decode_pkg::ALU_ADD;
    o_ctrl.alu_src2_sel = rv_decode_pkg::SRC2_RS2;
    bad                 = 1'b0;
    case (opcode)
      rv_decode_pkg::OP_LUI: begin
        o_ctrl.gpr_wen      = 1'b1;
        o_ctrl.alu_src2_sel = rv_decode_pkg::SRC2_IMM;
        o_ctrl.alu_op       = rv_decode_pkg::ALU_PASS_B;
      end
      rv_decode_pkg::OP_AUIPC: begin
        o_ctrl.gpr_wen      = 1'b1;
        o_ctrl.alu_src1_pc  = 1'b1;
        o_ctrl.alu_src2_sel = rv_decode_pkg::SRC2_IMM;
      end
      rv_decode_pkg::OP_JAL, rv_decode_pkg::OP_JALR: begin
        o_ctrl.gpr_wen      = 1'b1;
        o_ctrl.alu_src1_pc  = 1'b1;
        o_ctrl.alu_src2_sel = rv_decode_pkg::SRC2_FOUR;
        o_ctrl.jump         = 1'b1;
        o_ctrl.jalr         = (opcode == rv_decode_pkg::OP_JALR);
        bad                 = o_ctrl.jalr && (funct3 != 3'b000);
      end
      rv_decode_pkg::OP_BRANCH: begin
        o_ctrl.br_en   = 1'b1;
        o_ctrl.br_func = funct3;
        bad            = (funct3 == 3'b010) || (funct3 == 3'b011);
      end
      rv_decode_pkg::OP_LOAD: begin
        o_ctrl.gpr_wen      = 1'b1;
        o_ctrl.mem_ren      = 1'b1;
        o_ctrl.mem_op       = funct3;
        o_ctrl.alu_src2_sel = rv_decode_pkg::SRC2_IMM;
        bad                 = (funct3 == 3'b111);
      end
      rv_decode_pkg::OP_STORE: begin
        o_ctrl.mem_wen      = 1'b1;
        o_ctrl.mem_op       = funct3;
        o_ctrl.alu_src2_sel = rv_decode_pkg::SRC2_IMM;
        bad                 = funct3[2];
      end
      rv_decode_pkg::OP_IMM: begin
        o_ctrl.gpr_wen      = 1'b1;
        o_ctrl.alu_src2_sel = rv_decode_pkg::SRC2_IMM;
        o_ctrl.alu_op       = alu_from_f3(funct3, (funct3 == 3'b101) && funct7[5]);
        // 6-bit shamt, so funct7[0] belongs to it
        bad = ((funct3 == 3'b001) && (funct7[6:1] != 6'b000000)) ||
              ((funct3 == 3'b101) && (funct7[6:1] != 6'b000000) &&
               (funct7[6:1] != 6'b010000));
      end
      rv_decode_pkg::OP_IMM32: begin
        o_ctrl.gpr_wen      = 1'b1;
        o_ctrl.alu_word     = 1'b1;
        o_ctrl.alu_src2_sel = rv_decode_pkg::SRC2_IMM;
        o_ctrl.alu_op       = alu_from_f3(funct3, (funct3 == 3'b101) && funct7[5]);
        bad = !((funct3 == 3'b000) ||
                ((funct3 == 3'b001) && (funct7 == rv_decode_pkg::F7_BASE)) ||
                ((funct3 == 3'b101) && ((funct7 == rv_decode_pkg::F7_BASE) ||
                                        (funct7 == rv_decode_pkg::F7_ALT))));
      end
      rv_decode_pkg::OP_REG: begin
        o_ctrl.gpr_wen = 1'b1;
        o_ctrl.alu_op  = alu_from_f3(funct3, funct7[5]);
        bad = !((funct7 == rv_decode_pkg::F7_BASE) ||
                ((funct7 == rv_decode_pkg::F7_ALT) &&
                 ((funct3 == 3'b000) || (funct3 == 3'b101))));
      end
      rv_decode_pkg::OP_REG32: begin
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.alu_word = 1'b1;
        o_ctrl.alu_op   = alu_from_f3(funct3, funct7[5]);
        bad = !(((funct7 == rv_decode_pkg::F7_BASE) &&
                 ((funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b101))) ||
                ((funct7 == rv_decode_pkg::F7_ALT) &&
                 ((funct3 == 3'b000) || (funct3 == 3'b101))));
      end
      rv_decode_pkg::OP_SYSTEM: begin
        if (funct3 == 3'b000) begin
          bad = (i_inst.i.rs1 != '0) || (i_inst.i.rd != '0);
          case (i_inst.i.imm)
            rv_decode_pkg::SYS_ECALL:  o_ctrl.ecall  = 1'b1;
            rv_decode_pkg::SYS_EBREAK: o_ctrl.ebreak = 1'b1;
            rv_decode_pkg::SYS_MRET:   o_ctrl.mret   = 1'b1;
            default:                   bad           = 1'b1;
          endcase
        end else begin
          o_ctrl.csr_ren    = 1'b1; // csrrw/s/c and the immediate forms
          o_ctrl.csr_wen    = 1'b1;
          o_ctrl.gpr_wen    = 1'b1;
          o_ctrl.csr_to_gpr = 1'b1;
          o_ctrl.csr_op     = funct3;
          bad               = (funct3 == 3'b100);
        end
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      o_ctrl         = '0; // kills every enable and flag
      o_ctrl.invalid = 1'b1;
    end
  end

endmodule

/* logic/rv_decode_pkg.sv */
// widths, opcodes, function codes, stage bus structs and instruction format union
package rv_decode_pkg;

  localparam int XLEN   = 64;
  localparam int INST_W = 32;
  localparam int REG_AW = 5;
  localparam int CSR_AW = 12;

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_IMM32  = 7'b0011011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_REG32  = 7'b0111011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000; // sub / sra

  // branch funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // funct12 of the funct3 == 0 system group
  localparam logic [11:0] SYS_ECALL  = 12'h000;
  localparam logic [11:0] SYS_EBREAK = 12'h001;
  localparam logic [11:0] SYS_MRET   = 12'h302;

  localparam logic [CSR_AW-1:0] CSR_MSTATUS = 12'h300;
  localparam logic [CSR_AW-1:0] CSR_MTVEC   = 12'h305;
  localparam logic [CSR_AW-1:0] CSR_MEPC    = 12'h341;
  localparam logic [CSR_AW-1:0] CSR_MCAUSE  = 12'h342;

  localparam logic [XLEN-1:0] CAUSE_ECALL_M = 64'd11;

  // alu operand 2 select
  localparam logic [1:0] SRC2_RS2  = 2'd0;
  localparam logic [1:0] SRC2_IMM  = 2'd1;
  localparam logic [1:0] SRC2_FOUR = 2'd2; // link address pc + 4

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef struct packed {
    logic [6:0] funct7; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [4:0] rd;  logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm; logic [4:0] rs1; logic [2:0] funct3;
    logic [4:0]  rd;  logic [6:0] opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [4:0] imm_lo; logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic imm12; logic [5:0] imm10_5; logic [4:0] rs2; logic [4:0] rs1;
    logic [2:0] funct3; logic [3:0] imm4_1; logic imm11; logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm; logic [4:0] rd; logic [6:0] opcode;
  } u_fmt_t;

  typedef struct packed {
    logic imm20; logic [9:0] imm10_1; logic imm11; logic [7:0] imm19_12;
    logic [4:0] rd; logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

  typedef struct packed {
    inst_u           inst;
    logic [XLEN-1:0] pc;
  } fs_to_ds_t;

  typedef struct packed {
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic [XLEN-1:0]   csr_rdata;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   pc;
    logic              alu_src1_pc;
    logic [1:0]        alu_src2_sel;
    logic              alu_word;
    alu_op_e           alu_op;
    logic [REG_AW-1:0] rd;
    logic [CSR_AW-1:0] csr_addr;
    logic              gpr_wen;
    logic              csr_wen;
    logic              mem_ren;
    logic              mem_wen;
    logic [2:0]        mem_op;
    logic              csr_to_gpr; // csr read data goes to rd
    logic [2:0]        csr_op;
    logic              ebreak;
    logic              invalid;
  } ds_to_es_t;

  typedef struct packed {
    logic            taken;
    logic [XLEN-1:0] target;
  } br_t;

  typedef struct packed {
    logic              gpr_wen;
    logic [REG_AW-1:0] gpr_waddr;
    logic [XLEN-1:0]   gpr_wdata;
    logic              csr_wen;
    logic [CSR_AW-1:0] csr_waddr;
    logic [XLEN-1:0]   csr_wdata;
  } ws_to_rf_t;

  typedef struct packed {
    logic       alu_src1_pc;
    logic [1:0] alu_src2_sel;
    logic       alu_word;
    alu_op_e    alu_op;
    logic       gpr_wen;
    logic       csr_wen;
    logic       mem_ren;
    logic       mem_wen;
    logic [2:0] mem_op;
    logic       csr_to_gpr;
    logic [2:0] csr_op;
    logic       ebreak;
    logic       invalid;
    logic       br_en;   // stage-internal from here on
    logic [2:0] br_func;
    logic       jump;    // jal or jalr
    logic       jalr;
    logic       csr_ren;
    logic       ecall;
    logic       mret;
  } dec_ctrl_t;

endpackage

/* src.f */
logic/rv_decode_pkg.sv
logic/inst_decoder.sv
logic/gpr_file.sv
logic/csr_file.sv
logic/branch_unit.sv
logic/decode_stage.sv
testbench/decode_stage_props.sv
testbench/tb_decode_stage.sv

/* testbench/decode_stage_props.sv */
// handshake, reset and redirect assertions bound into the decode stage
`timescale 1ns/10ps

module decode_stage_props (
  input logic                     i_clk,
  input logic                     i_rst_n,
  input logic                     i_ds_allowin,
  input logic                     i_ds_to_es_valid,
  input logic                     i_es_allowin,
  input rv_decode_pkg::ds_to_es_t i_ds_to_es,
  input rv_decode_pkg::br_t       i_br
);

  // empty or leaving
  a_allowin : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_ds_allowin == (!i_ds_to_es_valid || i_es_allowin))
    else $error("allowin does not follow the empty-or-leaving rule");

  a_reset_valid : assert property (@(posedge i_clk) !i_rst_n |-> !i_ds_to_es_valid)
    else $error("stage valid while in reset");

  // held item and redirect stay put under back-pressure
  a_stall_stable : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (i_ds_to_es_valid && !i_es_allowin) |=>
      (i_ds_to_es_valid && $stable(i_ds_to_es) && $stable(i_br)))
    else $error("execute bundle changed during a stall");

  a_taken_valid : assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_br.taken |-> i_ds_to_es_valid)
    else $error("redirect taken without a valid item");

endmodule

/* testbench/decode_tests.txt */
# G addr data / C addr data : gpr or csr write-back (hex)
# I word pc rd imm rs1 rs2 csr_rdata gpr_wen mem_ren mem_wen csr_wen alu_op invalid taken target
G 1 5
G 2 fffffffffffffffd
G 3 5
G 0 deadbeef
C 305 1000
C 300 1888
I ff908293 80000000 5 fffffffffffffff9 5 1919191919191919 0 1 0 0 0 0 0 0 0
I 0020b823 80000004 10 10 5 fffffffffffffffd 0 0 0 1 0 0 0 0 0
I 12345337 80000008 6 12345000 808080808080808 5 0 1 0 0 0 a 0 0 0
I fffff397 8000000c 7 fffffffffffff000 1f1f1f1f1f1f1f1f 1f1f1f1f1f1f1f1f 0 1 0 0 0 0 0 0 0
I 00208433 80000010 8 2 5 fffffffffffffffd 0 1 0 0 0 0 0 0 0
I 002084bb 80000014 9 2 5 fffffffffffffffd 0 1 0 0 0 0 0 0 0
I 40118533 80000018 a 401 5 5 0 1 0 0 0 1 0 0 0
I 0081b583 8000001c b 8 5 808080808080808 0 1 1 0 0 0 0 0 0
I 00308863 80000020 10 10 5 5 0 0 0 0 0 0 0 1 80000030
I 00309863 80000024 10 10 5 5 0 0 0 0 0 0 0 0 0
I fe114ce3 80000028 19 fffffffffffffff8 fffffffffffffffd 5 0 0 0 0 0 0 0 1 80000020
I 0020f863 8000002c 10 10 5 fffffffffffffffd 0 0 0 0 0 0 0 0 0
I 100000ef 80000030 1 100 0 0 0 1 0 0 0 0 0 1 80000130
I 00308067 80000034 0 3 5 5 0 1 0 0 0 0 0 1 8
I 30009673 80000038 c 1 5 0 1888 1 0 0 1 0 0 0 0
I 00000073 8000003c 0 0 0 0 0 0 0 0 0 0 0 1 1000
I 341026f3 80000040 d 0 0 5 8000003c 1 0 0 1 0 0 0 0
I 34202773 80000044 e 0 0 fffffffffffffffd b 1 0 0 1 0 0 0 0
I 30200073 80000048 0 0 0 fffffffffffffffd 0 0 0 0 0 0 0 1 8000003c
I 000007b3 8000004c f 0 0 0 0 1 0 0 0 0 0 0 0
I ffffffff 80000050 1f ffffffffffffffff 1f1f1f1f1f1f1f1f 1f1f1f1f1f1f1f1f 0 0 0 0 0 0 1 0 0
I 02208433 80000054 8 22 5 fffffffffffffffd 0 0 0 0 0 0 1 0 0

/* testbench/tb_decode_stage.sv */
// testbench for the decode stage: file-driven records, register mirror and checks
`timescale 1ns/10ps

module tb_decode_stage;

  localparam int SEED      = 32839;
  localparam int MAX_WAIT  = 8;
  localparam int MAX_STALL = 6;

  logic                     clk;
  logic                     rst_n;
  logic                     fs_valid;
  rv_decode_pkg::fs_to_ds_t fs;
  logic                     ds_allowin;
  logic                     es_valid;
  rv_decode_pkg::ds_to_es_t es;
  logic                     es_allowin;
  rv_decode_pkg::br_t       br;
  rv_decode_pkg::ws_to_rf_t ws;

  logic [63:0] ref_gpr [0:31]; // mirror of every write-back
  logic [31:0] lcg_state;
  int          n_inst;
  logic [63:0] e_word, e_pc, e_rd, e_imm, e_rs1, e_rs2, e_csr;
  logic [63:0] e_gwen, e_mren, e_mwen, e_cwen, e_alu, e_inv, e_taken, e_target;

  decode_stage UUT (
    .i_clk            (clk),
    .i_rst_n          (rst_n),
    .i_fs_to_ds_valid (fs_valid),
    .i_fs_to_ds       (fs),
    .o_ds_allowin     (ds_allowin),
    .o_ds_to_es_valid (es_valid),
    .o_ds_to_es       (es),
    .i_es_allowin     (es_allowin),
    .o_br             (br),
    .i_ws_to_rf       (ws)
  );

  bind decode_stage decode_stage_props u_props (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_ds_allowin     (o_ds_allowin),
    .i_ds_to_es_valid (o_ds_to_es_valid),
    .i_es_allowin     (i_es_allowin),
    .i_ds_to_es       (o_ds_to_es),
    .i_br             (o_br)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    lcg_next  = lcg_state;
  endfunction

  // byte pattern built from the whole index
  function automatic logic [63:0] fill_word(input logic [4:0] r);
    fill_word = {8{3'b000, r}};
  endfunction

  task automatic abort(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      abort("value mismatch");
    end
  endtask

  task automatic gpr_write(input logic [4:0] a, input logic [63:0] d);
    @(negedge clk);
    ws.gpr_wen   = 1'b1;
    ws.gpr_waddr = a;
    ws.gpr_wdata = d;
    if (a != 5'd0) ref_gpr[a] = d; // x0 stays zero
    @(negedge clk);
    ws.gpr_wen = 1'b0;
  endtask

  task automatic csr_write(input logic [11:0] a, input logic [63:0] d);
    @(negedge clk);
    ws.csr_wen   = 1'b1;
    ws.csr_waddr = a;
    ws.csr_wdata = d;
    @(negedge clk);
    ws.csr_wen = 1'b0;
  endtask

  task automatic check_item();
    check("o_ds_to_es.pc", es.pc, e_pc);
    check("o_ds_to_es.rd", 64'(es.rd), e_rd);
    check("o_ds_to_es.imm", es.imm, e_imm);
    check("o_ds_to_es.rs1_data", es.rs1_data, e_rs1);
    check("o_ds_to_es.rs1_data mirror", es.rs1_data, ref_gpr[e_word[19:15]]);
    check("o_ds_to_es.rs2_data", es.rs2_data, e_rs2);
    check("o_ds_to_es.rs2_data mirror", es.rs2_data, ref_gpr[e_word[24:20]]);
    check("o_ds_to_es.csr_rdata", es.csr_rdata, e_csr);
    check("o_ds_to_es.gpr_wen", 64'(es.gpr_wen), e_gwen);
    check("o_ds_to_es.mem_ren", 64'(es.mem_ren), e_mren);
    check("o_ds_to_es.mem_wen", 64'(es.mem_wen), e_mwen);
    check("o_ds_to_es.csr_wen", 64'(es.csr_wen), e_cwen);
    check("o_ds_to_es.alu_op", 64'(es.alu_op), e_alu);
    check("o_ds_to_es.invalid", 64'(es.invalid), e_inv);
    check("o_br.taken", 64'(br.taken), e_taken);
    if (e_taken[0]) check("o_br.target", br.target, e_target);
  endtask

  task automatic run_inst();
    int          t;
    logic        left;
    logic [31:0] rnd;
    @(negedge clk);
    rnd        = lcg_next();
    fs_valid   = 1'b1;
    fs.inst    = e_word[31:0];
    fs.pc      = e_pc;
    es_allowin = rnd[16];
    @(negedge clk);
    fs_valid = 1'b0;
    t = 0;
    while (!es_valid) begin
      t++;
      if (t > MAX_WAIT) abort("instruction never reached the decode output");
      @(negedge clk);
    end
    t    = 0;
    left = 1'b0;
    // item is gone once valid falls
    while (es_valid) begin
      check_item();
      check("o_ds_allowin", 64'(ds_allowin), 64'(es_allowin));
      t++;
      if (t > MAX_WAIT + MAX_STALL) abort("instruction never left decode");
      rnd        = lcg_next();
      es_allowin = (t >= MAX_STALL) ? 1'b1 : rnd[16]; // bounded stall run
      left       = es_allowin;
      @(negedge clk);
    end
    check("i_es_allowin when o_ds_to_es_valid fell", 64'(left), 64'd1);
    check("o_ds_allowin after leave", 64'(ds_allowin), 64'd1);
    n_inst++;
  endtask

  initial begin
    int          fd;
    string       line;
    string       body;
    byte         kind;
    logic [63:0] a;
    logic [63:0] d;
    fs_valid   = 1'b0;
    fs         = '0;
    es_allowin = 1'b0;
    ws         = '0;
    rst_n      = 1'b0;
    lcg_state  = SEED;
    n_inst     = 0;
    for (int r = 0; r < 32; r++) ref_gpr[r] = 64'd0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check("o_ds_to_es_valid", 64'(es_valid), 64'd0);
    check("o_br.taken", 64'(br.taken), 64'd0);
    check("o_ds_allowin", 64'(ds_allowin), 64'd1);
    for (int r = 1; r < 32; r++) gpr_write(5'(r), fill_word(5'(r)));

    fd = $fopen("testbench/decode_tests.txt", "r");
    if (fd == 0) abort("cannot open the test record file");
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 3 || line.getc(0) == "#") continue;
      kind = line.getc(0);
      body = line.substr(2, line.len() - 1);
      case (kind)
        "G": begin
          void'($sscanf(body, "%h %h", a, d));
          gpr_write(a[4:0], d);
        end
        "C": begin
          void'($sscanf(body, "%h %h", a, d));
          csr_write(a[11:0], d);
        end
        "I": begin
          void'($sscanf(body, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        e_word, e_pc, e_rd, e_imm, e_rs1, e_rs2, e_csr, e_gwen,
                        e_mren, e_mwen, e_cwen, e_alu, e_inv, e_taken, e_target));
          run_inst();
        end
        default: abort("unknown record kind in the test file");
      endcase
    end
    $fclose(fd);

    if (n_inst > 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      abort("no instruction records were run");
    end
  end

endmodule
